// File: fp16_pkg.sv
// FP16 unit shared types
package fp16_pkg;

	// Field view of a half-precision word
	typedef struct packed {
		logic       sign;
		logic [4:0] exp;
		logic [9:0] man;
	} fp16_fields_t;

	// One word, decoded as raw bits or as fields
	typedef union packed {
		logic [15:0]  raw;
		fp16_fields_t f;
	} fp16_u;

	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		MUL = 3'd2,
		MIN = 3'd3,
		MAX = 3'd4
	} alu_op_e;

	// Command as stored in the input queue, 35 bits
	typedef struct packed {
		alu_op_e     op;
		logic [15:0] a;
		logic [15:0] b;
	} alu_cmd_t;

	// Queue depth, also the sender's starting input credits
	localparam int IN_DEPTH    = 4;
	localparam int IN_PTR_W    = $clog2(IN_DEPTH);
	localparam int IN_CNT_W    = $clog2(IN_DEPTH + 1);
	// Output credits held by the issue stage after reset
	localparam int OUT_CREDITS = 4;
	localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

	// Canonical quiet NaN
	localparam logic [15:0] QNAN = 16'h7E00;

endpackage

// File: alu_if.sv
// Issue to ALU interface
`timescale 1ns/1ps

interface alu_if (
	input logic clk
);
	// Command side, driven by the issue stage
	logic              valid;
	fp16_pkg::alu_op_e alu_op;
	logic [15:0]       alu_a;
	logic [15:0]       alu_b;
	// Result side, driven by the wrapper
	logic [15:0]       alu_res;
	logic              res_valid;

	modport issue_port (
		input  clk,
		output valid, alu_op, alu_a, alu_b,
		input  alu_res, res_valid
	);

	modport alu_port (
		input  clk,
		input  valid, alu_op, alu_a, alu_b,
		output alu_res, res_valid
	);

endinterface

// File: alu_cmd_queue.sv
// Credit-controlled command queue
`timescale 1ns/1ps

module alu_cmd_queue (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               push_i,
	input  fp16_pkg::alu_cmd_t cmd_i,
	input  logic               pop_i,
	output fp16_pkg::alu_cmd_t cmd_o,
	output logic               empty_o,
	output logic               credit_o
);
	// Entry storage
	fp16_pkg::alu_cmd_t mem [fp16_pkg::IN_DEPTH];

	logic [fp16_pkg::IN_PTR_W-1:0] wr_ptr;
	logic [fp16_pkg::IN_PTR_W-1:0] rd_ptr;
	logic [fp16_pkg::IN_CNT_W-1:0] count;
	logic                          pop_ok;

	// Pops only count when something is stored
	assign pop_ok   = pop_i && !empty_o;
	assign empty_o  = (count == '0);
	assign cmd_o    = mem[rd_ptr];
	// One credit back per entry leaving
	assign credit_o = pop_ok;

	// Write port, sender never pushes while full
	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= cmd_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == fp16_pkg::IN_PTR_W'(fp16_pkg::IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= (rd_ptr == fp16_pkg::IN_PTR_W'(fp16_pkg::IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count alone
			if (push_i && !pop_ok)
				count <= count + 1'b1;
			else if (!push_i && pop_ok)
				count <= count - 1'b1;
		end
	end

endmodule

// File: alu_issue.sv
// Issue stage with output credits
`timescale 1ns/1ps

module alu_issue (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               empty_i,
	input  fp16_pkg::alu_cmd_t cmd_i,
	output logic               pop_o,
	input  logic               res_credit_i,
	alu_if.issue_port          alu
);
	// Free output credits, 0 to OUT_CREDITS
	logic [fp16_pkg::OUT_CNT_W-1:0] credits;
	logic                           issue;

	// Issue needs a waiting command and a reserved result slot
	assign issue = !empty_i && (credits != '0);
	assign pop_o = issue;

	// Unpack the head command onto the bus
	assign alu.valid  = issue;
	assign alu.alu_op = cmd_i.op;
	assign alu.alu_a  = cmd_i.a;
	assign alu.alu_b  = cmd_i.b;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			credits <= fp16_pkg::OUT_CNT_W'(fp16_pkg::OUT_CREDITS);
		end else begin
			case ({issue, res_credit_i})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				// Spend and return together, no change
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: fp16_addsub.sv
// FP16 adder and subtractor
`timescale 1ns/1ps

module fp16_addsub (
	input  fp16_pkg::fp16_u a_i,
	input  fp16_pkg::fp16_u b_i,
	input  logic            sub_i,
	output fp16_pkg::fp16_u res_o
);
	fp16_pkg::fp16_u   b_eff;
	fp16_pkg::fp16_u   big;
	fp16_pkg::fp16_u   little;
	logic              a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic              eff_sub;
	logic [4:0]        diff;
	logic [24:0]       sm_full;
	logic [13:0]       big_m, sm_m, norm;
	logic [14:0]       sum;
	logic [3:0]        lz;
	logic signed [6:0] exp_n;
	logic [11:0]       mant_r;

	// Leading zeros of a 14-bit mantissa with G/R/S
	function automatic logic [3:0] lead_zeros(input logic [13:0] v);
		logic [3:0] n;
		n = 4'd14;
		for (int i = 0; i < 14; i++) begin
			if (v[i])
				n = 4'(13 - i);
		end
		return n;
	endfunction

	// Subtract is add with b negated
	assign b_eff.raw = {b_i.f.sign ^ sub_i, b_i.f.exp, b_i.f.man};
	assign eff_sub   = a_i.f.sign ^ b_eff.f.sign;

	assign a_nan  = (a_i.f.exp == 5'h1f) && (a_i.f.man != '0);
	assign b_nan  = (b_i.f.exp == 5'h1f) && (b_i.f.man != '0);
	assign a_inf  = (a_i.f.exp == 5'h1f) && (a_i.f.man == '0);
	assign b_inf  = (b_i.f.exp == 5'h1f) && (b_i.f.man == '0);
	// Subnormals count as zero
	assign a_zero = (a_i.f.exp == '0);
	assign b_zero = (b_i.f.exp == '0);

	always_comb begin
		// Larger magnitude leads and sets the sign
		if (a_i.raw[14:0] >= b_eff.raw[14:0]) begin
			big    = a_i;
			little = b_eff;
		end else begin
			big    = b_eff;
			little = a_i;
		end
		// Align the smaller operand and fold bits past R into sticky
		diff    = big.f.exp - little.f.exp;
		big_m   = {1'b1, big.f.man, 3'b000};
		sm_full = {1'b1, little.f.man, 14'b0} >> diff;
		sm_m    = (diff > 5'd13) ? 14'd1 : {sm_full[24:12], |sm_full[11:0]};
		sum     = eff_sub ? ({1'b0, big_m} - {1'b0, sm_m}) : ({1'b0, big_m} + {1'b0, sm_m});
		lz      = lead_zeros(sum[13:0]);
		// Carry out shifts right and cancellation shifts left
		if (sum[14]) begin
			norm  = {sum[14:2], |sum[1:0]};
			exp_n = $signed({2'b00, big.f.exp}) + 7'sd1;
		end else begin
			norm  = sum[13:0] << lz;
			exp_n = $signed({2'b00, big.f.exp}) - $signed({3'b000, lz});
		end
		// Nearest even on guard, round and sticky
		mant_r = {1'b0, norm[13:3]} + 12'(norm[2] & (norm[3] | norm[1] | norm[0]));
		// Rounding carry leaves the fraction at zero and bumps the exponent
		if (mant_r[11])
			exp_n = exp_n + 7'sd1;

		if (a_nan || b_nan || (a_inf && b_inf && eff_sub))
			res_o.raw = fp16_pkg::QNAN;
		else if (a_inf)
			res_o = a_i;
		else if (b_inf)
			res_o = b_eff;
		else if (a_zero && b_zero)
			res_o.raw = {a_i.f.sign & b_eff.f.sign, 15'b0};
		else if (a_zero)
			res_o = b_eff;
		else if (b_zero)
			res_o = a_i;
		else if (sum == '0)
			res_o.raw = 16'h0000; // exact cancellation gives +0
		else if (exp_n >= 7'sd31)
			res_o.raw = {big.f.sign, 5'h1f, 10'h000};
		else if (exp_n <= 7'sd0)
			res_o.raw = {big.f.sign, 15'b0};
		else
			res_o.raw = {big.f.sign, exp_n[4:0], mant_r[9:0]};
	end

endmodule

// File: fp16_mul.sv
// FP16 multiplier
`timescale 1ns/1ps

module fp16_mul (
	input  fp16_pkg::fp16_u a_i,
	input  fp16_pkg::fp16_u b_i,
	output fp16_pkg::fp16_u res_o
);
	logic              sign;
	logic              a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
	logic [21:0]       prod;
	logic [21:0]       pn;
	logic signed [6:0] exp_n;
	logic [11:0]       mant_r;

	assign sign   = a_i.f.sign ^ b_i.f.sign;
	assign a_nan  = (a_i.f.exp == 5'h1f) && (a_i.f.man != '0);
	assign b_nan  = (b_i.f.exp == 5'h1f) && (b_i.f.man != '0);
	assign a_inf  = (a_i.f.exp == 5'h1f) && (a_i.f.man == '0);
	assign b_inf  = (b_i.f.exp == 5'h1f) && (b_i.f.man == '0);
	// Subnormals count as zero
	assign a_zero = (a_i.f.exp == '0);
	assign b_zero = (b_i.f.exp == '0);

	// 11x11 significand product
	assign prod = {1'b1, a_i.f.man} * {1'b1, b_i.f.man};

	always_comb begin
		// Product in [1,4), at most one position to normalize
		pn    = prod[21] ? prod : (prod << 1);
		exp_n = $signed({2'b00, a_i.f.exp}) + $signed({2'b00, b_i.f.exp}) - 7'sd15;
		if (prod[21])
			exp_n = exp_n + 7'sd1;
		// Keep 11 bits, guard at bit 10, rest is sticky
		mant_r = {1'b0, pn[21:11]} + 12'(pn[10] & (pn[11] | (|pn[9:0])));
		// Rounding carry leaves the fraction at zero and bumps the exponent
		if (mant_r[11])
			exp_n = exp_n + 7'sd1;

		if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
			res_o.raw = fp16_pkg::QNAN;
		else if (a_inf || b_inf)
			res_o.raw = {sign, 5'h1f, 10'h000};
		else if (a_zero || b_zero)
			res_o.raw = {sign, 15'b0};
		else if (exp_n >= 7'sd31)
			res_o.raw = {sign, 5'h1f, 10'h000};
		// Underflow flushes to signed zero
		else if (exp_n <= 7'sd0)
			res_o.raw = {sign, 15'b0};
		else
			res_o.raw = {sign, exp_n[4:0], mant_r[9:0]};
	end

endmodule

// File: alu_wrap.sv
// Two-stage FP16 arithmetic pipeline
`timescale 1ns/1ps

module alu_wrap (
	input  logic    clk,
	input  logic    rst_i,
	alu_if.alu_port p
);
	// Stage 1 registers
	logic              s1_valid;
	fp16_pkg::alu_op_e s1_op;
	fp16_pkg::fp16_u   s1_a, s1_b;
	// Between stages
	fp16_pkg::fp16_u   add_res, mul_res, sel_res;
	fp16_pkg::fp16_u   cmp_a, cmp_b;
	logic              any_nan, a_lt_b;

	always_ff @(posedge clk) begin
		if (rst_i)
			s1_valid <= 1'b0;
		else
			s1_valid <= p.valid;
	end

	always_ff @(posedge clk) begin
		s1_op     <= p.alu_op;
		s1_a.raw  <= p.alu_a;
		s1_b.raw  <= p.alu_b;
	end

	fp16_addsub u_addsub (
		.a_i   (s1_a),
		.b_i   (s1_b),
		.sub_i (s1_op == fp16_pkg::SUB),
		.res_o (add_res)
	);

	fp16_mul u_mul (
		.a_i   (s1_a),
		.b_i   (s1_b),
		.res_o (mul_res)
	);

	// Compare on flushed operands, subnormal becomes signed zero
	assign cmp_a.raw = (s1_a.f.exp == '0) ? {s1_a.f.sign, 15'b0} : s1_a.raw;
	assign cmp_b.raw = (s1_b.f.exp == '0) ? {s1_b.f.sign, 15'b0} : s1_b.raw;
	assign any_nan   = ((s1_a.f.exp == 5'h1f) && (s1_a.f.man != '0)) ||
	                   ((s1_b.f.exp == 5'h1f) && (s1_b.f.man != '0));

	// Sign-magnitude order, -0 sits below +0
	always_comb begin
		if (cmp_a.f.sign != cmp_b.f.sign)
			a_lt_b = cmp_a.f.sign;
		else if (cmp_a.f.sign)
			a_lt_b = cmp_a.raw[14:0] > cmp_b.raw[14:0];
		else
			a_lt_b = cmp_a.raw[14:0] < cmp_b.raw[14:0];
	end

	always_comb begin
		case (s1_op)
			fp16_pkg::ADD, fp16_pkg::SUB: sel_res = add_res;
			fp16_pkg::MUL:                sel_res = mul_res;
			fp16_pkg::MIN:                sel_res.raw = any_nan ? fp16_pkg::QNAN :
			                                            (a_lt_b ? cmp_a.raw : cmp_b.raw);
			fp16_pkg::MAX:                sel_res.raw = any_nan ? fp16_pkg::QNAN :
			                                            (a_lt_b ? cmp_b.raw : cmp_a.raw);
			default:                      sel_res.raw = fp16_pkg::QNAN;
		endcase
	end

	// Stage 2 drives the result side
	always_ff @(posedge clk) begin
		if (rst_i)
			p.res_valid <= 1'b0;
		else
			p.res_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		p.alu_res <= sel_res.raw;
	end

endmodule

// File: alu_top.sv
// FP16 arithmetic unit top level
`timescale 1ns/1ps

module alu_top (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              in_valid_i,
	input  fp16_pkg::alu_op_e in_op_i,
	input  logic [15:0]       in_a_i,
	input  logic [15:0]       in_b_i,
	output logic              in_credit_o,
	output logic              res_valid_o,
	output logic [15:0]       res_o,
	input  logic              res_credit_i
);
	fp16_pkg::alu_cmd_t in_cmd;
	fp16_pkg::alu_cmd_t q_cmd;
	logic               q_pop;
	logic               q_empty;

	// Issue stage to wrapper
	alu_if u_bus (
		.clk (clk)
	);

	// Pack the incoming command
	assign in_cmd = {in_op_i, in_a_i, in_b_i};

	alu_cmd_queue u_queue (
		.clk      (clk),
		.rst_i    (rst_i),
		.push_i   (in_valid_i),
		.cmd_i    (in_cmd),
		.pop_i    (q_pop),
		.cmd_o    (q_cmd),
		.empty_o  (q_empty),
		.credit_o (in_credit_o)
	);

	alu_issue u_issue (
		.clk          (clk),
		.rst_i        (rst_i),
		.empty_i      (q_empty),
		.cmd_i        (q_cmd),
		.pop_o        (q_pop),
		.res_credit_i (res_credit_i),
		.alu          (u_bus.issue_port)
	);

	alu_wrap u_wrap (
		.clk   (clk),
		.rst_i (rst_i),
		.p     (u_bus.alu_port)
	);

	// Results leave straight from stage 2
	assign res_valid_o = u_bus.res_valid;
	assign res_o       = u_bus.alu_res;

endmodule

// File: tb_alu_top.sv
// FP16 unit testbench
`timescale 1ns/1ps

module tb_alu_top;
	localparam int TIMEOUT = 200;
	// Quiet cycles watched while output credits are withheld
	localparam int WINDOW  = 12;
	localparam int MAX_VEC = 64;

	logic              clk;
	logic              rst_i;
	logic              in_valid_i;
	fp16_pkg::alu_op_e in_op_i;
	logic [15:0]       in_a_i;
	logic [15:0]       in_b_i;
	logic              in_credit_o;
	logic              res_valid_o;
	logic [15:0]       res_o;
	logic              res_credit_i;

	// Five words per vector holding control, op, a, b and expected
	logic [15:0] vec_mem [5*MAX_VEC];
	// Expected results and send cycles in command order
	logic [15:0] exp_q [$];
	int          sent_q [$];
	// Cycles at which the receiver returns an output credit
	int          ret_q [$];
	int          cycle;
	int          in_cred;
	int          credit_pulses;
	int          sent;
	int          held;
	int          idx;
	bit          withhold;
	integer      seed;

	alu_top u_alu_top (
		.clk          (clk),
		.rst_i        (rst_i),
		.in_valid_i   (in_valid_i),
		.in_op_i      (in_op_i),
		.in_a_i       (in_a_i),
		.in_b_i       (in_b_i),
		.in_credit_o  (in_credit_o),
		.res_valid_o  (res_valid_o),
		.res_o        (res_o),
		.res_credit_i (res_credit_i)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic compare(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("CHECKS FAILED");
		$fatal(1, "run aborted");
	endtask

	// Advance to the next falling edge where outputs are sampled and input pulses cleared
	task automatic step();
		logic [15:0] want;
		int          issued;
		@(negedge clk);
		cycle++;
		in_valid_i   = 1'b0;
		res_credit_i = 1'b0;
		if (in_credit_o) begin
			in_cred++;
			credit_pulses++;
			if (in_cred > fp16_pkg::IN_DEPTH)
				abort_run("more input credits came back than commands were sent");
		end
		if (res_valid_o) begin
			if (exp_q.size() == 0)
				abort_run("a result arrived with no command outstanding");
			want   = exp_q.pop_front();
			issued = sent_q.pop_front();
			compare("res_o", int'(res_o), int'(want));
			// Queue, issue and two pipeline stages
			if (cycle - issued < 3)
				abort_run("a result arrived less than three cycles after its command");
			if (withhold)
				held++;
			else
				ret_q.push_back(cycle + ($unsigned($random(seed)) % 4));
		end
		// Oldest due credit goes back first
		if (ret_q.size() > 0 && ret_q[0] <= cycle) begin
			res_credit_i = 1'b1;
			void'(ret_q.pop_front());
		end
	endtask

	// Drive one vector once an input credit is held
	task automatic send(input int v);
		int t;
		t = 0;
		while (in_cred == 0) begin
			step();
			t++;
			if (t > TIMEOUT)
				abort_run("no input credit came back for the next command");
		end
		step();
		in_valid_i = 1'b1;
		in_op_i    = fp16_pkg::alu_op_e'(vec_mem[5*v+1][2:0]);
		in_a_i     = vec_mem[5*v+2];
		in_b_i     = vec_mem[5*v+3];
		in_cred--;
		sent++;
		exp_q.push_back(vec_mem[5*v+4]);
		sent_q.push_back(cycle);
	endtask

	// Wait for every result and every returned output credit
	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() > 0 || ret_q.size() > 0) begin
			step();
			t++;
			if (t > TIMEOUT)
				abort_run("outstanding results or output credits never completed");
		end
	endtask

	// Ends a hold phase and checks the stall before credits go back
	task automatic release_credits();
		int t;
		int pulses_before;
		t = 0;
		while (held < fp16_pkg::OUT_CREDITS) begin
			step();
			t++;
			if (t > TIMEOUT)
				abort_run("results covered by the free output credits never arrived");
		end
		pulses_before = credit_pulses;
		repeat (WINDOW) step();
		compare("results while credits withheld", held, fp16_pkg::OUT_CREDITS);
		compare("in_credit_o pulses while stalled", credit_pulses, pulses_before);
		withhold = 1'b0;
		for (int i = 0; i < held; i++)
			ret_q.push_back(cycle + i);
		held = 0;
	endtask

	initial begin
		seed          = 20515;
		cycle         = 0;
		in_cred       = fp16_pkg::IN_DEPTH;
		credit_pulses = 0;
		sent          = 0;
		held          = 0;
		withhold      = 1'b0;
		rst_i         = 1'b1;
		in_valid_i    = 1'b0;
		in_op_i       = fp16_pkg::ADD;
		in_a_i        = 16'h0000;
		in_b_i        = 16'h0000;
		res_credit_i  = 1'b0;
		// Unused slots carry bit 15 as an end marker
		for (int i = 0; i < 5*MAX_VEC; i++)
			vec_mem[i] = 16'h8000 | 16'(i);
		$readmemh("fp16_tests.txt", vec_mem);
		repeat (8) @(negedge clk);
		rst_i = 1'b0;
		for (idx = 0; idx < MAX_VEC && !vec_mem[5*idx][15]; idx++) begin
			// Control bit 0 set means the receiver withholds credits
			if (vec_mem[5*idx][0] && !withhold) begin
				drain();
				withhold = 1'b1;
				held     = 0;
			end else if (!vec_mem[5*idx][0] && withhold) begin
				release_credits();
			end
			send(idx);
		end
		if (withhold)
			release_credits();
		drain();
		compare("sender input credits at end", in_cred, fp16_pkg::IN_DEPTH);
		compare("total in_credit_o pulses", credit_pulses, sent);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: fp16_tests.txt
// Columns: control op a b expected, all hex; control 1 = receiver withholds credits
// Op: 0 ADD, 1 SUB, 2 MUL, 3 MIN, 4 MAX
0 0 3C00 4000 4200
0 1 3C00 4000 BC00
0 2 3E00 4000 4200
0 2 C200 3800 BE00
0 0 3C00 1000 3C00
0 0 3C01 1000 3C02
0 0 7BFF 7BFF 7C00
0 0 0001 3C00 3C00
1 0 7C01 3C00 7E00
1 1 7C00 7C00 7E00
1 2 0000 7C00 7E00
1 2 F800 7800 FC00
1 2 8400 0400 8000
1 1 8001 0001 8000
1 3 7E00 3C00 7E00
1 4 3C00 FE01 7E00
0 3 3C00 BC00 BC00
0 4 3C00 BC00 3C00
0 3 0000 8000 8000
0 4 8000 0000 0000
0 3 C000 BC00 C000
0 3 8001 0000 8000

// File: flist.f
fp16_pkg.sv
alu_if.sv
alu_cmd_queue.sv
alu_issue.sv
fp16_addsub.sv
fp16_mul.sv
alu_wrap.sv
alu_top.sv
tb_alu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the FP16 unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_alu_top -o sim_alu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_alu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
